// ==== logic/tile_pkg.sv ====
package tile_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   localparam int NR_MASTERS = 2;                   // 0 instruction port, 1 data port
   localparam int NR_SLAVES  = 3;
   localparam int MST_IDX_W  = $clog2(NR_MASTERS);

   localparam int SLV_RAM = 0;
   localparam int SLV_MP  = 1;
   localparam int SLV_ROM = 2;

   localparam logic [3:0] REGION_MP  = 4'hE;
   localparam logic [3:0] REGION_ROM = 4'hF;

   localparam int RAM_WORDS     = 1024;
   localparam int RAM_IDX_W     = $clog2(RAM_WORDS);
   localparam int MP_FIFO_DEPTH = 4;
   localparam int MP_PTR_W      = $clog2(MP_FIFO_DEPTH);
   localparam int BOOT_WORDS    = 8;
   localparam int BOOT_IDX_W    = $clog2(BOOT_WORDS);

   localparam logic [DATA_W-1:0] BOOT_IMAGE [BOOT_WORDS] = '{
      32'h1500_0000, 32'h1500_0001, 32'h1500_0002, 32'h1500_0003,
      32'h1500_0004, 32'h1500_0005, 32'h1500_0006, 32'h1500_0007
   };

   // Decoder looks at the region, slaves at the word index
   typedef union packed {
      logic [ADDR_W-1:0] word;
      struct packed {
         logic [3:0]        region;
         logic [ADDR_W-5:0] offset;
      } f;
   } bus_addr_u;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      bus_addr_u         adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic              err;
      logic [DATA_W-1:0] dat;                       // Valid with ack on a read
   } wb_rsp_t;

endpackage

// ==== logic/wb_bus_arbiter.sv ====
`timescale 1ns/1ps

module wb_bus_arbiter
   import tile_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset_i,
   input  wb_req_t [NR_MASTERS-1:0]   m_req_i,
   output wb_rsp_t [NR_MASTERS-1:0]   m_rsp_o,
   output wb_req_t [NR_SLAVES-1:0]    s_req_o,
   input  wb_rsp_t [NR_SLAVES-1:0]    s_rsp_i
);

   logic [NR_MASTERS-1:0] grant_q;
   logic [NR_MASTERS-1:0] pick_oh;
   logic [MST_IDX_W-1:0]  ptr_q;
   logic [MST_IDX_W-1:0]  gnt_idx;
   logic                  gnt_vld;
   wb_req_t               gnt_req;
   logic [NR_SLAVES-1:0]  slv_oh;
   logic                  unmapped;
   logic                  loc_err_q;
   wb_rsp_t               rsp_mux;

   // First requester at or after the pointer
   always_comb begin : pick_p
      int idx;
      pick_oh = '0;
      for (int k = NR_MASTERS - 1; k >= 0; k--) begin
         idx = (int'(ptr_q) + k) % NR_MASTERS;
         if (m_req_i[idx].cyc) begin
            pick_oh      = '0;
            pick_oh[idx] = 1'b1;
         end
      end
   end

   always_comb begin
      gnt_idx = '0;
      for (int k = 0; k < NR_MASTERS; k++) begin
         if (grant_q[k]) gnt_idx = MST_IDX_W'(k);
      end
   end

   assign gnt_vld = |grant_q;
   assign gnt_req = m_req_i[gnt_idx];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         grant_q <= '0;
         ptr_q   <= '0;
      end else if (!gnt_vld) begin
         grant_q <= pick_oh;                        // Stays zero when nobody asks
      end else if (!gnt_req.cyc) begin
         grant_q <= '0;
         ptr_q   <= (gnt_idx == MST_IDX_W'(NR_MASTERS - 1)) ? '0 : gnt_idx + 1'b1;
      end
   end

   always_comb begin
      slv_oh   = '0;
      unmapped = 1'b0;
      if (!gnt_req.adr.f.region[3])                 // Lower half is local SRAM
         slv_oh[SLV_RAM] = 1'b1;
      else if (gnt_req.adr.f.region == REGION_MP)
         slv_oh[SLV_MP] = 1'b1;
      else if (gnt_req.adr.f.region == REGION_ROM)
         slv_oh[SLV_ROM] = 1'b1;
      else
         unmapped = 1'b1;
   end

   always_comb begin
      for (int s = 0; s < NR_SLAVES; s++) begin
         s_req_o[s]     = gnt_req;
         s_req_o[s].cyc = gnt_vld & slv_oh[s] & gnt_req.cyc;
         s_req_o[s].stb = gnt_vld & slv_oh[s] & gnt_req.stb;
      end
   end

   // Holes in the map answer here
   always_ff @(posedge clk) begin
      if (reset_i)
         loc_err_q <= 1'b0;
      else
         loc_err_q <= gnt_vld & gnt_req.cyc & gnt_req.stb & unmapped & ~loc_err_q;
   end

   always_comb begin
      rsp_mux = '0;
      for (int s = 0; s < NR_SLAVES; s++) begin
         if (slv_oh[s]) rsp_mux = s_rsp_i[s];
      end
      rsp_mux.err = rsp_mux.err | loc_err_q;
      for (int m = 0; m < NR_MASTERS; m++) begin
         m_rsp_o[m] = grant_q[m] ? rsp_mux : '0;
      end
   end

   assert property (@(posedge clk) disable iff (reset_i) $onehot0(grant_q));

   for (genvar m = 0; m < NR_MASTERS; m++) begin : g_rsp_chk
      // A response needs a grant held over a live cycle one clock earlier
      assert property (@(posedge clk) disable iff (reset_i)
         (m_rsp_o[m].ack || m_rsp_o[m].err) |-> $past(grant_q[m] && m_req_i[m].cyc));
   end

endmodule

// ==== logic/tile_sram.sv ====
`timescale 1ns/1ps

module tile_sram
   import tile_pkg::*;
(
   input  logic    clk,
   input  logic    reset_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   logic [DATA_W-1:0]    mem [RAM_WORDS];
   logic [RAM_IDX_W-1:0] widx;
   logic                 acc;
   logic                 ack_q;
   logic [DATA_W-1:0]    rdat_q;

   assign widx = req_i.adr.word[RAM_IDX_W+1:2];     // Wraps every RAM_WORDS words
   assign acc  = req_i.cyc & req_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (acc && req_i.we) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (req_i.sel[b])
               mem[widx][b*(DATA_W/SEL_W) +: DATA_W/SEL_W] <=
                  req_i.dat[b*(DATA_W/SEL_W) +: DATA_W/SEL_W];
         end
      end
      if (acc && !req_i.we)
         rdat_q <= mem[widx];
   end

   always_ff @(posedge clk) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= acc;                              // One-cycle ack per access
   end

   assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

// ==== logic/tile_bootrom.sv ====
`timescale 1ns/1ps

module tile_bootrom
   import tile_pkg::*;
(
   input  logic    clk,
   input  logic    reset_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   logic [BOOT_IDX_W-1:0] widx;
   logic                  acc;
   logic                  ack_q;
   logic                  err_q;
   logic [DATA_W-1:0]     dat_q;

   assign widx = req_i.adr.word[BOOT_IDX_W+1:2];
   assign acc  = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= acc & ~req_i.we;
         err_q <= acc & req_i.we;                   // Writes are refused
      end
   end

   always_ff @(posedge clk) begin
      if (acc)
         dat_q <= BOOT_IMAGE[widx];
   end

   assign rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

   // Exactly one kind of answer, and only to a strobe seen last cycle
   assert property (@(posedge clk) disable iff (reset_i)
      (rsp_o.ack || rsp_o.err) |->
         !(rsp_o.ack && rsp_o.err) && $past(req_i.cyc && req_i.stb));

endmodule

// ==== logic/mp_endpoint.sv ====
`timescale 1ns/1ps

module mp_endpoint
   import tile_pkg::*;
(
   input  logic              clk,
   input  logic              reset_i,
   input  wb_req_t           req_i,
   output wb_rsp_t           rsp_o,
   input  logic [DATA_W-1:0] noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output logic [DATA_W-1:0] noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   output logic              irq_o
);

   logic [1:0]        push;                         // Index 0 send, 1 receive
   logic [1:0]        pop;
   logic [1:0]        full;
   logic [1:0]        empty;
   logic [DATA_W-1:0] din  [2];
   logic [DATA_W-1:0] head [2];

   logic [ADDR_W-5:2] widx;                         // Word index inside the region
   logic              acc;
   logic              ok;
   logic [DATA_W-1:0] rdat;
   logic              ack_q;
   logic              err_q;
   logic [DATA_W-1:0] dat_q;

   assign din[0] = req_i.dat;
   assign din[1] = noc_in_flit_i;

   for (genvar c = 0; c < 2; c++) begin : g_fifo
      logic [DATA_W-1:0]   mem_q [MP_FIFO_DEPTH];
      logic [MP_PTR_W-1:0] wr_q;
      logic [MP_PTR_W-1:0] rd_q;
      logic [MP_PTR_W:0]   cnt_q;

      assign full[c]  = (cnt_q == MP_FIFO_DEPTH);
      assign empty[c] = (cnt_q == '0);
      assign head[c]  = mem_q[rd_q];

      always_ff @(posedge clk) begin
         if (push[c])
            mem_q[wr_q] <= din[c];
      end

      always_ff @(posedge clk) begin
         if (reset_i) begin
            wr_q  <= '0;
            rd_q  <= '0;
            cnt_q <= '0;
         end else begin
            if (push[c]) wr_q <= wr_q + 1'b1;
            if (pop[c])  rd_q <= rd_q + 1'b1;
            if (push[c] && !pop[c])
               cnt_q <= cnt_q + 1'b1;
            else if (pop[c] && !push[c])
               cnt_q <= cnt_q - 1'b1;
         end
      end

      // Write pointer frozen while full
      assert property (@(posedge clk) disable iff (reset_i) full[c] |=> $stable(wr_q));
   end

   assign acc  = req_i.cyc & req_i.stb & ~(ack_q | err_q);
   assign widx = req_i.adr.word[ADDR_W-5:2];

   always_comb begin
      ok   = 1'b0;
      rdat = '0;
      if (widx == '0) begin
         if (req_i.we) begin
            ok = !full[0];
         end else begin
            ok   = !empty[1];
            rdat = head[1];
         end
      end else if (widx == 1 && !req_i.we) begin
         ok   = 1'b1;
         rdat = {{(DATA_W-2){1'b0}}, full[0], !empty[1]};  // Status word
      end
   end

   assign push[0] = acc & ok & req_i.we;
   assign pop[1]  = acc & ok & ~req_i.we & (widx == '0);
   assign pop[0]  = ~empty[0] & noc_out_ready_i;
   assign push[1] = noc_in_valid_i & ~full[1];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= acc & ok;
         err_q <= acc & ~ok;
      end
   end

   always_ff @(posedge clk) begin
      if (acc)
         dat_q <= rdat;
   end

   assign rsp_o           = '{ack: ack_q, err: err_q, dat: dat_q};
   assign noc_out_valid_o = ~empty[0];
   assign noc_out_flit_o  = head[0];
   assign noc_in_ready_o  = ~full[1];
   assign irq_o           = ~empty[1];              // Words waiting to be read

endmodule

// ==== logic/compute_tile.sv ====
`timescale 1ns/1ps

module compute_tile
   import tile_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset_i,
   input  wb_req_t [NR_MASTERS-1:0]   m_req_i,
   output wb_rsp_t [NR_MASTERS-1:0]   m_rsp_o,
   input  logic [DATA_W-1:0]          noc_in_flit_i,
   input  logic                       noc_in_valid_i,
   output logic                       noc_in_ready_o,
   output logic [DATA_W-1:0]          noc_out_flit_o,
   output logic                       noc_out_valid_o,
   input  logic                       noc_out_ready_i,
   output logic                       irq_o
);

   wb_req_t [NR_SLAVES-1:0] s_req;
   wb_rsp_t [NR_SLAVES-1:0] s_rsp;

   wb_bus_arbiter u_bus (
      .clk     (clk),
      .reset_i (reset_i),
      .m_req_i (m_req_i),
      .m_rsp_o (m_rsp_o),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   tile_sram u_ram (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (s_req[SLV_RAM]),
      .rsp_o   (s_rsp[SLV_RAM])
   );

   mp_endpoint u_mp (
      .clk             (clk),
      .reset_i         (reset_i),
      .req_i           (s_req[SLV_MP]),
      .rsp_o           (s_rsp[SLV_MP]),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

   tile_bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (s_req[SLV_ROM]),
      .rsp_o   (s_rsp[SLV_ROM])
   );

endmodule

// ==== verif/compute_tile_tb.sv ====
`timescale 1ns/1ps

module compute_tile_tb import tile_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int RSP_LIMIT  = 20;                  // Cycles a bus access may take
   localparam int WAIT_LIMIT = 100;
   localparam int SEC_B      = 14;                  // First endpoint send row
   localparam int SEC_C      = 20;                  // First endpoint receive row
   localparam int NR_ROWS    = 26;

   typedef struct {
      string       name;
      int          mst;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [31:0] exp;
      logic        exp_err;
   } row_t;

   logic                      clk = 1'b0;
   logic                      reset_i;
   wb_req_t [NR_MASTERS-1:0]  m_req;
   wb_rsp_t [NR_MASTERS-1:0]  m_rsp;
   logic [31:0]               noc_in_flit_i;
   logic                      noc_in_valid_i;
   logic                      noc_in_ready_o;
   logic [31:0]               noc_out_flit_o;
   logic                      noc_out_valid_o;
   logic                      noc_out_ready_i;
   logic                      irq_o;

   row_t        tbl [NR_ROWS];
   logic [31:0] in_flits [3];
   logic [31:0] out_q [$];
   integer      seed = 32'hb1b2;
   int          errors = 0;
   int          in_idx = 0;
   logic        drain_en = 1'b0;
   logic        send_en = 1'b0;

   compute_tile u_compute_tile (
      .clk             (clk),
      .reset_i         (reset_i),
      .m_req_i         (m_req),
      .m_rsp_o         (m_rsp),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Network side, all decisions taken on the falling edge
   always @(negedge clk) begin : noc_model
      int r;
      if (drain_en) begin
         r = $random(seed);
         noc_out_ready_i = r[0];                    // Random back-pressure
      end else begin
         noc_out_ready_i = 1'b0;
      end
      if (noc_out_valid_o && noc_out_ready_i)
         out_q.push_back(noc_out_flit_o);          // Pops on the next rising edge
      noc_in_valid_i = 1'b0;
      if (send_en && in_idx < 3 && noc_in_ready_o) begin
         noc_in_valid_i = 1'b1;
         noc_in_flit_i  = in_flits[in_idx];
         in_idx++;
      end
   end

   initial begin : watchdog
      #((NR_ROWS * 20 + 400) * CLK_PERIOD);
      $display("Timeout: the run did not finish in time, %0d errors so far", errors);
      $display(">>> FAIL");
      $finish;
   end

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
      errors++;
      $display("FAIL %s: %s expected %h actual %h", name, what, exp, act);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic set_row(input int i, input string name, input int mst, input logic we,
                          input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [31:0] exp,
                          input logic exp_err);
      tbl[i] = '{name, mst, we, adr, dat, sel, exp, exp_err};
   endtask

   task automatic build_table();
      set_row(0,  "ram_wr_full",   1, 1, 32'h0000_0100, 32'h1122_3344, 4'hF, 0, 0);
      set_row(1,  "ram_wr_b0",     1, 1, 32'h0000_0100, 32'hAAAA_AA55, 4'h1, 0, 0);
      set_row(2,  "ram_wr_b3",     1, 1, 32'h0000_0100, 32'h99BB_BBBB, 4'h8, 0, 0);
      set_row(3,  "ram_rd_merge",  0, 0, 32'h0000_0100, 0, 4'hF, 32'h9922_3355, 0);
      set_row(4,  "ram_rd_alias",  0, 0, 32'h100 + 4 * RAM_WORDS, 0, 4'hF,
              32'h9922_3355, 0);
      set_row(5,  "ram_wr_alias",  1, 1, 32'h104 + 4 * RAM_WORDS, 32'h5A5A_0F0F, 4'hF, 0, 0);
      set_row(6,  "ram_rd_alias2", 0, 0, 32'h0000_0104, 0, 4'hF, 32'h5A5A_0F0F, 0);
      set_row(7,  "rom_rd_0",      0, 0, 32'hF000_0000, 0, 4'hF, 32'h1500_0000, 0);
      set_row(8,  "rom_rd_5",      1, 0, 32'hF000_0014, 0, 4'hF, 32'h1500_0005, 0);
      set_row(9,  "rom_rd_wrap",   0, 0, 32'hF000_0028, 0, 4'hF, 32'h1500_0002, 0);
      set_row(10, "rom_wr",        1, 1, 32'hF000_0004, 32'hFFFF_FFFF, 4'hF, 0, 1);
      set_row(11, "rom_rd_1",      0, 0, 32'hF000_0004, 0, 4'hF, 32'h1500_0001, 0);
      set_row(12, "hole_rd",       0, 0, 32'hA000_0000, 0, 4'hF, 0, 1);
      set_row(13, "hole_wr",       1, 1, 32'hA000_0010, 32'h0000_1234, 4'hF, 0, 1);
      for (int k = 0; k < 4; k++)
         set_row(SEC_B + k, $sformatf("mp_wr_%0d", k), 1, 1, 32'hE000_0000,
                 32'hC0DE_0000 + k, 4'hF, 0, 0);
      set_row(18, "mp_wr_full",    1, 1, 32'hE000_0000, 32'hDEAD_0005, 4'hF, 0, 1);
      set_row(19, "mp_status_tx",  1, 0, 32'hE000_0004, 0, 4'hF, 32'h0000_0002, 0);
      set_row(20, "mp_status_rx",  1, 0, 32'hE000_0004, 0, 4'hF, 32'h0000_0001, 0);
      for (int k = 0; k < 3; k++)
         set_row(SEC_C + 1 + k, $sformatf("mp_rd_%0d", k), 1, 0, 32'hE000_0000, 0, 4'hF,
                 in_flits[k], 0);
      set_row(24, "mp_rd_empty",   1, 0, 32'hE000_0000, 0, 4'hF, 0, 1);
      set_row(25, "mp_bad_offset", 0, 0, 32'hE000_0008, 0, 4'hF, 0, 1);
   endtask

   task automatic apply_row(input int i);
      row_t    r;
      wb_rsp_t rsp;
      int      lat;
      r   = tbl[i];
      rsp = '0;
      lat = 0;
      m_req[r.mst].cyc      = 1'b1;
      m_req[r.mst].stb      = 1'b1;
      m_req[r.mst].we       = r.we;
      m_req[r.mst].adr.word = r.adr;
      m_req[r.mst].dat      = r.dat;
      m_req[r.mst].sel      = r.sel;
      while (!(rsp.ack || rsp.err) && lat < RSP_LIMIT) begin
         @(negedge clk);
         lat++;
         rsp = m_rsp[r.mst];
      end
      m_req[r.mst] = '0;
      @(negedge clk);                               // Idle cycle between accesses
      if (!(rsp.ack || rsp.err)) begin
         report_problem($sformatf("%s: no ack or err within %0d cycles", r.name, RSP_LIMIT));
      end else begin
         if (rsp.err !== r.exp_err)
            report_mismatch(r.name, "err", r.exp_err, rsp.err);
         if (lat != 2)                              // Idle bus answers in two cycles
            report_mismatch(r.name, "latency", 2, lat);
         if (!r.we && !r.exp_err && rsp.dat !== r.exp)
            report_mismatch(r.name, "data", r.exp, rsp.dat);
      end
   endtask

   task automatic run_rows(input int lo, input int hi);
      for (int i = lo; i < hi; i++)
         apply_row(i);
   endtask

   // Both masters ask in the same cycle, round robin starts at master 0
   task automatic arbitrate_pair();
      wb_rsp_t     rsp;
      int          lat [NR_MASTERS];
      int          exp_lat [NR_MASTERS];
      logic [31:0] exp_dat [NR_MASTERS];
      exp_lat = '{2, 5};                            // Clear, re-grant and slave edges
      exp_dat = '{32'h1500_0001, 32'h1500_0006};
      lat     = '{0, 0};
      for (int m = 0; m < NR_MASTERS; m++) begin
         m_req[m].cyc      = 1'b1;
         m_req[m].stb      = 1'b1;
         m_req[m].adr.word = (m == 0) ? 32'hF000_0004 : 32'hF000_0018;
         m_req[m].sel      = 4'hF;
      end
      for (int c = 1; c <= RSP_LIMIT && (lat[0] == 0 || lat[1] == 0); c++) begin
         @(negedge clk);
         for (int m = 0; m < NR_MASTERS; m++) begin
            rsp = m_rsp[m];
            if (lat[m] == 0 && (rsp.ack || rsp.err)) begin
               lat[m]   = c;
               m_req[m] = '0;
               if (rsp.err || rsp.dat !== exp_dat[m])
                  report_mismatch($sformatf("arb_m%0d", m), "data", exp_dat[m], rsp.dat);
            end
         end
      end
      m_req = '0;
      @(negedge clk);
      for (int m = 0; m < NR_MASTERS; m++) begin
         if (lat[m] == 0)
            report_problem($sformatf("arb_m%0d: master got no response", m));
         else if (lat[m] != exp_lat[m])
            report_mismatch($sformatf("arb_m%0d", m), "latency", exp_lat[m], lat[m]);
      end
   endtask

   initial begin : main
      int w;
      reset_i         = 1'b1;
      m_req           = '0;
      noc_in_flit_i   = '0;
      noc_in_valid_i  = 1'b0;
      noc_out_ready_i = 1'b0;
      for (int k = 0; k < 3; k++)
         in_flits[k] = $random(seed);
      build_table();
      repeat (10) @(negedge clk);
      reset_i = 1'b0;

      if (m_rsp[0].ack || m_rsp[0].err || m_rsp[1].ack || m_rsp[1].err)
         report_problem("after_reset: a response is active with no request");
      if (noc_out_valid_o !== 1'b0)
         report_mismatch("after_reset", "noc_out_valid_o", 0, noc_out_valid_o);
      if (noc_in_ready_o !== 1'b1)
         report_mismatch("after_reset", "noc_in_ready_o", 1, noc_in_ready_o);
      if (irq_o !== 1'b0)
         report_mismatch("after_reset", "irq_o", 0, irq_o);

      arbitrate_pair();
      run_rows(0, SEC_C);                           // Send FIFO stays blocked

      drain_en = 1'b1;
      w = 0;
      while (out_q.size() < 4 && w < WAIT_LIMIT) begin
         @(negedge clk);
         w++;
      end
      repeat (4) @(negedge clk);
      if (out_q.size() != 4) begin
         report_mismatch("mp_drain", "flit count", 4, out_q.size());
      end else begin
         for (int k = 0; k < 4; k++)
            if (out_q[k] !== tbl[SEC_B + k].dat)
               report_mismatch("mp_drain", $sformatf("flit %0d", k), tbl[SEC_B + k].dat,
                               out_q[k]);
      end

      send_en = 1'b1;
      w = 0;
      while (in_idx < 3 && w < WAIT_LIMIT) begin
         @(negedge clk);
         w++;
      end
      @(negedge clk);                               // Last flit lands in the FIFO
      if (in_idx < 3)
         report_problem("mp_receive: the network link did not accept all flits");
      if (irq_o !== 1'b1)
         report_mismatch("mp_irq_rise", "irq_o", 1, irq_o);
      run_rows(SEC_C, NR_ROWS);
      if (irq_o !== 1'b0)
         report_mismatch("mp_irq_fall", "irq_o", 0, irq_o);

      $display("Checks done: %0d errors", errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== files.f ====
logic/tile_pkg.sv
logic/wb_bus_arbiter.sv
logic/tile_sram.sv
logic/tile_bootrom.sv
logic/mp_endpoint.sv
logic/compute_tile.sv
verif/compute_tile_tb.sv

// ==== Bender.yml ====
package:
  name: compute_tile

sources:
  - logic/tile_pkg.sv
  - logic/wb_bus_arbiter.sv
  - logic/tile_sram.sv
  - logic/tile_bootrom.sv
  - logic/mp_endpoint.sv
  - logic/compute_tile.sv
  - target: simulation
    files:
      - verif/compute_tile_tb.sv
